/* Bender.yml */
package:
  name: irq_ctrl

sources:
  - irq_pkg.sv
  - irq_csr_regs.sv
  - irq_arbiter.sv
  - wfi_sleep_ctrl.sv
  - irq_ctrl_top.sv
  - target: test
    files:
      - tb_irq_ctrl.sv

/* files.f */
irq_pkg.sv
irq_csr_regs.sv
irq_arbiter.sv
wfi_sleep_ctrl.sv
irq_ctrl_top.sv
tb_irq_ctrl.sv

/* irq_arbiter.sv */
// --------------------
// Interrupt arbiter
// Flops the external lines into mip, picks a winner by
// fixed priority and issues a one-cycle claim
// --------------------

`timescale 1ns/1ps

module irq_arbiter
  import irq_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [NUM_IRQ-1:0] irq_i,
  input  irq_cfg_t           cfg_i,
  output logic [NUM_IRQ-1:0] mip_o,
  output logic               pending_enabled_o,
  output irq_claim_t         claim_o
);

  logic [NUM_IRQ-1:0]  mip_q;
  logic [NUM_IRQ-1:0]  pend_en;
  logic                win_valid;
  logic [IRQ_ID_W-1:0] win_id;
  irq_claim_t          claim_q;

  // --------------------
  // Pending register

  // Reserved lines never reach mip
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & VALID_IRQ_MASK;
    end
  end

  assign pend_en           = mip_q & cfg_i.mie;
  assign pending_enabled_o = |pend_en;
  assign mip_o             = mip_q;

  // --------------------
  // Winner selection

  // Later assignments win, so lowest priority goes first
  // Order is 31..16, then 11, then 3, then 7
  always_comb begin
    win_valid = 1'b0;
    win_id    = '0;
    if (pend_en[7]) begin
      win_valid = 1'b1;
      win_id    = IRQ_ID_W'(7);
    end
    if (pend_en[3]) begin
      win_valid = 1'b1;
      win_id    = IRQ_ID_W'(3);
    end
    if (pend_en[11]) begin
      win_valid = 1'b1;
      win_id    = IRQ_ID_W'(11);
    end
    for (int i = 16; i < NUM_IRQ; i++) begin
      if (pend_en[i]) begin
        win_valid = 1'b1;
        win_id    = IRQ_ID_W'(i);
      end
    end
  end

  // --------------------
  // Claim pulse

  // MIE clears one edge after the claim, so block the back-to-back cycle here
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      claim_q <= '0;
    end else begin
      claim_q.valid <= win_valid & cfg_i.mstatus_mie & ~claim_q.valid;
      claim_q.id    <= win_id;
    end
  end

  assign claim_o = claim_q;

  a_claim_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    claim_o.valid |=> !claim_o.valid
  );

  // Claimed id was the winner and was enabled when it was picked
  a_claim_id_enabled: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    claim_o.valid |-> VALID_IRQ_MASK[claim_o.id] && claim_o.id == $past(win_id)
                      && $past(cfg_i.mie[win_id])
  );

  a_mip_not_reserved: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mip_q & ~VALID_IRQ_MASK) == '0
  );

endmodule

/* irq_csr_regs.sv */
// --------------------
// Machine interrupt CSRs on APB
// Holds mie, mstatus and mcause, reads back mip,
// and performs trap entry on a claim
// --------------------

`timescale 1ns/1ps

module irq_csr_regs
  import irq_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  apb_req_t           apb_req_i,
  output apb_rsp_t           apb_rsp_o,
  input  logic [NUM_IRQ-1:0] mip_i,
  input  irq_claim_t         claim_i,
  output irq_cfg_t           cfg_o
);

  logic [NUM_IRQ-1:0]  mie_q;
  logic                mstatus_mie_q;
  logic                mstatus_mpie_q;
  logic                mcause_irq_q;
  logic [IRQ_ID_W-1:0] mcause_id_q;

  logic        access;
  logic        addr_hit;
  logic        wr_err;
  logic        wr_ok;
  logic [31:0] rdata;

  // --------------------
  // Access phase decode

  // Setup phase does nothing, all work happens with penable
  assign access = apb_req_i.psel & apb_req_i.penable;

  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    case (apb_req_i.paddr)
      MIE_OFFS: rdata = mie_q;
      MSTATUS_OFFS: begin
        rdata[MSTATUS_MIE_BIT]  = mstatus_mie_q;
        rdata[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
      end
      MCAUSE_OFFS: rdata = {mcause_irq_q, {(32-1-IRQ_ID_W){1'b0}}, mcause_id_q};
      MIP_OFFS: rdata = mip_i;
      default: addr_hit = 1'b0;
    endcase
  end

  // mcause and mip are read-only
  assign wr_err = apb_req_i.pwrite &
                  ((apb_req_i.paddr == MCAUSE_OFFS) | (apb_req_i.paddr == MIP_OFFS));
  assign wr_ok  = access & apb_req_i.pwrite & addr_hit & ~wr_err;

  // No wait states ever
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = access & (~addr_hit | wr_err);
  assign apb_rsp_o.prdata  = rdata;

  // --------------------
  // Register state

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q          <= '0;
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mcause_irq_q   <= 1'b0;
      mcause_id_q    <= '0;
    end else begin
      // Reserved enable bits stay zero
      if (wr_ok && apb_req_i.paddr == MIE_OFFS) begin
        mie_q <= apb_req_i.pwdata & VALID_IRQ_MASK;
      end
      // Trap entry wins over a write to mstatus in the same cycle
      if (claim_i.valid) begin
        mstatus_mpie_q <= mstatus_mie_q;
        mstatus_mie_q  <= 1'b0;
        mcause_irq_q   <= 1'b1;
        mcause_id_q    <= claim_i.id;
      end else if (wr_ok && apb_req_i.paddr == MSTATUS_OFFS) begin
        mstatus_mie_q  <= apb_req_i.pwdata[MSTATUS_MIE_BIT];
        mstatus_mpie_q <= apb_req_i.pwdata[MSTATUS_MPIE_BIT];
      end
    end
  end

  assign cfg_o.mie         = mie_q;
  assign cfg_o.mstatus_mie = mstatus_mie_q;

  // Enable word only ever holds implemented lines
  a_mie_not_reserved: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mie_q & ~VALID_IRQ_MASK) == '0
  );

endmodule

/* irq_ctrl_golden.txt */
# Columns: test number, op code (decimal), then hex words a and b
# Ops: 0 write a=b, 1 write a=b expecting pslverr, 2 read a expecting b, 3 read a expecting pslverr
# Ops: 4 drive irq lines b, 5 retire instruction b with err a, 6 debug request level a
# Ops: 7 wait up to a cycles for claim id b (ff none), 8 after a edges expect core sleep b
1 0 00 ffffffff
1 2 00 ffff0888
1 0 04 ffffffff
1 2 04 00000088
1 3 10 00000000
1 1 0c 12345678
2 0 00 00000000
2 4 00 ffffffff
2 2 0c ffff0888
3 4 00 00000888
3 0 00 ffffffff
3 7 08 0000000b
3 2 08 8000000b
3 2 04 00000080
3 4 00 00000088
3 0 04 00000008
3 7 08 00000003
3 4 00 00000080
3 0 04 00000008
3 7 08 00000007
3 4 00 00100800
3 0 04 00000008
3 7 08 00000014
4 4 00 00000008
4 0 00 00000000
4 0 04 00000008
4 7 08 000000ff
4 0 04 00000000
4 0 00 00000008
4 7 08 000000ff
4 0 04 00000008
4 7 08 00000003
5 4 00 00000000
5 5 00 00000013
5 5 01 10500073
5 8 02 00000000
5 5 00 10500073
5 8 01 00000001
5 4 00 00000008
5 8 01 00000000
5 4 00 00000000
5 5 00 10500073
5 8 02 00000001
5 6 01 00000000
5 8 00 00000000
5 6 00 00000000

/* irq_ctrl_top.sv */
// --------------------
// Interrupt controller top
// Register block, arbiter and WFI sleep control
// --------------------

`timescale 1ns/1ps

module irq_ctrl_top
  import irq_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  // APB register port
  input  apb_req_t           apb_req_i,
  output apb_rsp_t           apb_rsp_o,
  // External interrupt lines
  input  logic [NUM_IRQ-1:0] irq_i,
  // Writeback stage and debug
  input  wb_instr_t          wb_instr_i,
  input  logic               debug_req_i,
  // Towards the core
  output irq_claim_t         irq_claim_o,
  output logic               core_sleep_o
);

  irq_cfg_t           cfg;
  logic [NUM_IRQ-1:0] mip;
  logic               pending_enabled;
  irq_claim_t         claim;

  irq_csr_regs irq_csr_regs_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .mip_i     (mip),
    .claim_i   (claim),
    .cfg_o     (cfg)
  );

  irq_arbiter irq_arbiter_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .irq_i             (irq_i),
    .cfg_i             (cfg),
    .mip_o             (mip),
    .pending_enabled_o (pending_enabled),
    .claim_o           (claim)
  );

  // Claim goes to the core and back into trap entry
  assign irq_claim_o = claim;

  wfi_sleep_ctrl wfi_sleep_ctrl_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .wb_instr_i        (wb_instr_i),
    .pending_enabled_i (pending_enabled),
    .debug_req_i       (debug_req_i),
    .core_sleep_o      (core_sleep_o)
  );

endmodule

/* irq_pkg.sv */
// --------------------
// Interrupt controller package
// Line counts, valid-line mask, APB register map,
// WFI encoding and the structs shared by all blocks
// --------------------

package irq_pkg;

  // --------------------
  // Sizes and encodings

  localparam int unsigned NUM_IRQ    = 32;
  localparam int unsigned IRQ_ID_W   = 5;
  localparam int unsigned APB_ADDR_W = 8;

  // Implemented lines 31..16, 11, 7 and 3
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hFFFF_0888;

  // Full WFI instruction word, no don't-care bits
  localparam logic [31:0] WFI_INSTR = 32'h1050_0073;

  // --------------------
  // Register map

  localparam logic [APB_ADDR_W-1:0] MIE_OFFS     = 8'h00;
  localparam logic [APB_ADDR_W-1:0] MSTATUS_OFFS = 8'h04;
  localparam logic [APB_ADDR_W-1:0] MCAUSE_OFFS  = 8'h08;
  localparam logic [APB_ADDR_W-1:0] MIP_OFFS     = 8'h0C;

  // mstatus fields that are implemented
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

  // --------------------
  // Shared structs

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [31:0]           pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // One-cycle claim towards the core, no ack
  typedef struct packed {
    logic                valid;
    logic [IRQ_ID_W-1:0] id;
  } irq_claim_t;

  // Enables from the register block to the arbiter
  typedef struct packed {
    logic [NUM_IRQ-1:0] mie;
    logic               mstatus_mie;
  } irq_cfg_t;

  // Instruction leaving writeback
  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
    logic        err;
  } wb_instr_t;

endpackage

/* tb_irq_ctrl.sv */
// --------------------
// Interrupt controller testbench
// Replays the golden operation list against the DUT
// and checks register, claim and sleep behavior
// --------------------

`timescale 1ns/1ps

module tb_irq_ctrl
  import irq_pkg::*;
();

  localparam int    MAX_OPS       = 64;
  localparam int    CYCLES_PER_OP = 20;
  localparam string GOLDEN_FILE   = "irq_ctrl_golden.txt";

  logic               clk_i;
  logic               rst_ni;
  apb_req_t           apb_req;
  apb_rsp_t           apb_rsp;
  logic [NUM_IRQ-1:0] irq;
  wb_instr_t          wb_instr;
  logic               debug_req;
  irq_claim_t         irq_claim;
  logic               core_sleep;

  // Golden operations, one entry per data line
  int          test_id [MAX_OPS];
  int          op_code [MAX_OPS];
  logic [31:0] arg_a   [MAX_OPS];
  logic [31:0] arg_b   [MAX_OPS];
  int          num_ops     = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          test_errors = 0;
  int          pass_count  = 0;
  int          fail_count  = 0;

  irq_ctrl_top irq_ctrl_top_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .apb_req_i    (apb_req),
    .apb_rsp_o    (apb_rsp),
    .irq_i        (irq),
    .wb_instr_i   (wb_instr),
    .debug_req_i  (debug_req),
    .irq_claim_o  (irq_claim),
    .core_sleep_o (core_sleep)
  );

  // --------------------
  // Clock and run limit

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Run aborted after %0d cycles without finishing the golden list", cycle_count);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // --------------------
  // Helpers

  task automatic load_golden();
    int          fd;
    int          n;
    int          t;
    int          op;
    logic [31:0] a;
    logic [31:0] b;
    string       line;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("Could not open %s for reading", GOLDEN_FILE);
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // Lines starting with # describe the columns
        if (line.len() > 1 && line[0] != "#" && num_ops < MAX_OPS) begin
          n = $sscanf(line, "%d %d %h %h", t, op, a, b);
          if (n == 4) begin
            test_id[num_ops] = t;
            op_code[num_ops] = op;
            arg_a[num_ops]   = a;
            arg_b[num_ops]   = b;
            num_ops++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
    test_errors++;
  endtask

  // Setup phase, access phase, then idle; sampled mid access phase
  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk_i);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    @(negedge clk_i);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    // Slave never inserts wait states
    if (apb_rsp.pready !== 1'b1) begin
      report_mismatch("pready", 32'(apb_rsp.pready), 32'h1);
    end
    @(posedge clk_i);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
  endtask

  // Id ff means no claim may show up in the window
  task automatic wait_claim(input int max_cycles, input logic [31:0] exp_id);
    int                  i;
    logic                seen;
    logic [IRQ_ID_W-1:0] id;
    seen = 1'b0;
    id   = '0;
    for (i = 0; i < max_cycles && !seen; i++) begin
      @(negedge clk_i);
      if (irq_claim.valid) begin
        seen = 1'b1;
        id   = irq_claim.id;
      end
    end
    if (exp_id == 32'hff && seen) begin
      report_mismatch("claim id where none was due", 32'(id), exp_id);
    end else if (exp_id != 32'hff && !seen) begin
      $display("No claim arrived within %0d cycles at time %0t", max_cycles, $time);
      test_errors++;
    end else if (seen && id != exp_id[IRQ_ID_W-1:0]) begin
      report_mismatch("claim id", 32'(id), exp_id);
    end
  endtask

  task automatic run_op(input int idx);
    logic [31:0] rd;
    logic        err;
    case (op_code[idx])
      0, 1: begin
        apb_access(1'b1, arg_a[idx][7:0], arg_b[idx], rd, err);
        if (err !== (op_code[idx] == 1)) begin
          report_mismatch("write pslverr", 32'(err), 32'(op_code[idx]));
        end
      end
      2: begin
        apb_access(1'b0, arg_a[idx][7:0], '0, rd, err);
        if (err !== 1'b0) report_mismatch("read pslverr", 32'(err), 32'h0);
        if (rd !== arg_b[idx]) report_mismatch("read data", rd, arg_b[idx]);
      end
      3: begin
        apb_access(1'b0, arg_a[idx][7:0], '0, rd, err);
        if (err !== 1'b1) report_mismatch("read pslverr", 32'(err), 32'h1);
      end
      4: begin
        @(posedge clk_i);
        irq <= arg_b[idx];
      end
      // One retire cycle from writeback
      5: begin
        @(posedge clk_i);
        wb_instr.valid <= 1'b1;
        wb_instr.rdata <= arg_b[idx];
        wb_instr.err   <= arg_a[idx][0];
        @(posedge clk_i);
        wb_instr.valid <= 1'b0;
      end
      6: begin
        @(posedge clk_i);
        debug_req <= arg_a[idx][0];
      end
      7: wait_claim(int'(arg_a[idx]), arg_b[idx]);
      8: begin
        repeat (int'(arg_a[idx])) @(posedge clk_i);
        @(negedge clk_i);
        if (core_sleep !== arg_b[idx][0]) begin
          report_mismatch("core_sleep", 32'(core_sleep), arg_b[idx]);
        end
      end
      default: begin
        $display("Golden line %0d has unknown operation code %0d", idx, op_code[idx]);
        test_errors++;
      end
    endcase
  endtask

  task automatic finish_test(input int t);
    if (test_errors == 0) begin
      $display("Test %0d: pass", t);
      pass_count++;
    end else begin
      $display("Test %0d: fail with %0d errors", t, test_errors);
      fail_count++;
    end
    test_errors = 0;
  endtask

  // --------------------
  // Main sequence

  initial begin
    int i;
    int prev_test;
    rst_ni    = 1'b0;
    apb_req   = '0;
    irq       = '0;
    wb_instr  = '0;
    debug_req = 1'b0;
    prev_test = -1;
    load_golden();
    cycle_limit = CYCLES_PER_OP * num_ops;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (i = 0; i < num_ops; i++) begin
      if (prev_test >= 0 && test_id[i] != prev_test) finish_test(prev_test);
      prev_test = test_id[i];
      run_op(i);
    end
    if (prev_test >= 0) finish_test(prev_test);
    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && num_ops > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* wfi_sleep_ctrl.sv */
// --------------------
// WFI sleep control
// Tracks a retired WFI and drives core sleep until
// an enabled interrupt or a debug request wakes the core
// --------------------

`timescale 1ns/1ps

module wfi_sleep_ctrl
  import irq_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  wb_instr_t wb_instr_i,
  input  logic      pending_enabled_i,
  input  logic      debug_req_i,
  output logic      core_sleep_o
);

  logic is_wfi;
  logic wake;
  logic in_wfi_q;
  logic sleep_q;

  // Only a clean retire of the exact WFI word counts
  assign is_wfi = wb_instr_i.valid & ~wb_instr_i.err & (wb_instr_i.rdata == WFI_INSTR);

  // Global MIE plays no part in wakeup
  assign wake = pending_enabled_i | debug_req_i;

  // --------------------
  // WFI state and sleep flop

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_wfi_q <= 1'b0;
      sleep_q  <= 1'b0;
    end else begin
      if (is_wfi) begin
        in_wfi_q <= 1'b1;
      end else if (wake) begin
        in_wfi_q <= 1'b0;
      end
      // Sleep one edge after entering WFI
      sleep_q <= in_wfi_q & ~wake;
    end
  end

  // Wake drops sleep in the same cycle
  assign core_sleep_o = sleep_q & ~wake;

  a_sleep_in_wfi: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o |-> in_wfi_q
  );

  a_sleep_fall_exits_wfi: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(core_sleep_o) && in_wfi_q |=> !in_wfi_q
  );

endmodule
